// ==== daf_macros.svh ====
/*
 * daf constants
 * sizes of the flanger delay line and its LFO sweep,
 * plus the fixed input to output latency of the pipeline
 */
`ifndef DAF_MACROS_SVH
`define DAF_MACROS_SVH

`default_nettype none

// delay memory entries, a power of two so pointers wrap
`define DAF_FLANGE_DEPTH 256

// shortest tap distance in samples
`define DAF_MIN_DELAY 8

// LFO steps, sweep runs 0 .. span-1 and back
`define DAF_LFO_SPAN 64

// cycles from in_valid to out_valid
`define DAF_LATENCY 5

`default_nettype wire

`endif

// ==== daf_audio_pkg.sv ====
/*
 * daf audio types
 * signed 16-bit samples and the stereo word, left in the high half
 */
`default_nettype none

package daf_audio_pkg;

  localparam int SAMPLE_W = 16;

  // one signed audio sample
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // one bit of headroom for sums and magnitudes
  typedef logic signed [SAMPLE_W:0] sample_ext_t;

  // matches the input word, left in bits 31:16, right in bits 15:0
  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_t;

  // largest and smallest representable sample
  localparam sample_t SAMPLE_MAX = sample_t'(16'sh7fff);
  localparam sample_t SAMPLE_MIN = sample_t'(16'sh8000);

  // pack two channels into a stereo word
  function automatic stereo_t make_stereo(sample_t l, sample_t r);
    stereo_t s;
    s.left = l;
    s.right = r;
    return s;
  endfunction

endpackage

`default_nettype wire

// ==== daf_ctrl_pkg.sv ====
/*
 * daf control types
 * potentiometer readings, effect enable switches and level scaling
 */
`default_nettype none

package daf_ctrl_pkg;

  localparam int POT_W = 4;
  // one pot step is 2048 sample counts
  localparam int POT_STEP_SH = 11;

  // pot reading, 0 to 15
  typedef logic [POT_W-1:0] pot_t;

  // same order as swch_mode_en[3:0]
  typedef struct packed {
    logic flange_en;
    logic clip_en;
    logic comp_en;
    logic fade_en;
  } mode_t;

  // (p + 1) * 2048 - 1, i.e. the pot value above eleven ones
  function automatic logic [POT_W+POT_STEP_SH-1:0] pot_level(pot_t p);
    return {p, {POT_STEP_SH{1'b1}}};
  endfunction

endpackage

`default_nettype wire

// ==== sample_if.sv ====
/*
 * sample_if
 * one stereo sample with its valid strobe and saturation flag,
 * passed between pipeline stages without any stall
 */
`timescale 1ns/1ps
`default_nettype none

interface sample_if;
  import daf_audio_pkg::*;

  logic    valid;
  sample_t left;
  sample_t right;
  // some stage limited this sample
  logic    sat;

  modport source (output valid, output left, output right, output sat);
  modport sink   (input valid, input left, input right, input sat);

endinterface

`default_nettype wire

// ==== flanger.sv ====
/*
 * flanger
 * stereo delay line swept by a triangle LFO, mixed half and half
 * with the dry sample; includes the sequencer that zeroes the memory
 */
`timescale 1ns/1ps
`include "daf_macros.svh"
`default_nettype none

module flanger (
  input  wire logic                     tb_clk,
  input  wire logic                     rst_n,
  input  wire logic                     in_valid,
  input  wire daf_audio_pkg::stereo_t   in_smp,
  input  wire logic                     flange_en,
  input  wire logic                     mem_clr,
  output logic                          clr_busy,
  sample_if.source                      out
);
  import daf_audio_pkg::*;

  localparam int PTR_W = $clog2(`DAF_FLANGE_DEPTH);
  localparam int LFO_W = $clog2(`DAF_LFO_SPAN);

  stereo_t          mem [`DAF_FLANGE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] clr_ptr;
  logic [PTR_W-1:0] tap_dist;
  logic [PTR_W-1:0] rd_addr;
  logic [LFO_W-1:0] lfo_pos;
  logic             lfo_up;
  logic             accept;
  logic             clr_start;
  logic             s1_valid;
  stereo_t          s1_dry;
  stereo_t          s1_tap;
  sample_ext_t      sum_l;
  sample_ext_t      sum_r;

  // samples offered during a clear are dropped
  assign accept    = in_valid && !clr_busy;
  assign clr_start = mem_clr && !clr_busy;

  // tap uses the LFO position before this sample steps it
  assign tap_dist = PTR_W'(`DAF_MIN_DELAY) + PTR_W'(lfo_pos);
  assign rd_addr  = wr_ptr - tap_dist;

  // clear sequencer, one zero write per cycle
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      clr_busy <= 1'b0;
      clr_ptr  <= '0;
    end else if (clr_start) begin
      clr_busy <= 1'b1;
      clr_ptr  <= '0;
    end else if (clr_busy) begin
      clr_ptr <= clr_ptr + 1'b1;
      if (clr_ptr == PTR_W'(`DAF_FLANGE_DEPTH - 1)) begin
        clr_busy <= 1'b0;
      end
    end
  end

  // write pointer and triangle LFO
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      lfo_pos <= '0;
      lfo_up  <= 1'b1;
    end else if (clr_start) begin
      wr_ptr  <= '0;
      lfo_pos <= '0;
      lfo_up  <= 1'b1;
    end else if (accept) begin
      wr_ptr <= wr_ptr + 1'b1;
      // reverse at either end and keep stepping
      if (lfo_up) begin
        if (lfo_pos == LFO_W'(`DAF_LFO_SPAN - 1)) begin
          lfo_up  <= 1'b0;
          lfo_pos <= lfo_pos - 1'b1;
        end else begin
          lfo_pos <= lfo_pos + 1'b1;
        end
      end else begin
        if (lfo_pos == '0) begin
          lfo_up  <= 1'b1;
          lfo_pos <= lfo_pos + 1'b1;
        end else begin
          lfo_pos <= lfo_pos - 1'b1;
        end
      end
    end
  end

  // delay memory, synchronous read of the tap
  always_ff @(posedge tb_clk) begin
    if (clr_busy) begin
      mem[clr_ptr] <= '0;
    end else if (accept) begin
      mem[wr_ptr] <= in_smp;
    end
    s1_tap <= mem[rd_addr];
    s1_dry <= in_smp;
  end

  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      out.valid <= 1'b0;
    end else begin
      s1_valid  <= accept;
      out.valid <= s1_valid;
    end
  end

  // (dry + tap) >>> 1 per channel
  assign sum_l = sample_ext_t'(s1_dry.left) + sample_ext_t'(s1_tap.left);
  assign sum_r = sample_ext_t'(s1_dry.right) + sample_ext_t'(s1_tap.right);

  always_ff @(posedge tb_clk) begin
    if (flange_en) begin
      out.left  <= sum_l[16:1];
      out.right <= sum_r[16:1];
    end else begin
      out.left  <= s1_dry.left;
      out.right <= s1_dry.right;
    end
  end

  // the mix never saturates
  assign out.sat = 1'b0;

endmodule

`default_nettype wire

// ==== amp_dynamics.sv ====
/*
 * amp_dynamics
 * hard clipper stage followed by a threshold compressor stage,
 * both levels set in steps of 2048 by their pots
 */
`timescale 1ns/1ps
`default_nettype none

module amp_dynamics (
  input  wire logic                tb_clk,
  input  wire logic                rst_n,
  input  wire logic                clip_en,
  input  wire logic                comp_en,
  input  wire daf_ctrl_pkg::pot_t  pot_amp_clp,
  input  wire daf_ctrl_pkg::pot_t  pot_amp_com,
  sample_if.sink                   in,
  sample_if.source                 out
);
  import daf_audio_pkg::*;
  import daf_ctrl_pkg::*;

  sample_ext_t clip_lim;
  sample_ext_t comp_thr;
  sample_t     clip_l;
  sample_t     clip_r;
  logic        c_valid;
  sample_t     c_left;
  sample_t     c_right;
  logic        c_sat;

  // limit to +/- lim
  function automatic sample_t clip_ch(sample_t x, sample_ext_t lim);
    sample_ext_t xe;
    xe = sample_ext_t'(x);
    if (xe > lim) return sample_t'(lim);
    if (xe < -lim) return sample_t'(-lim);
    return x;
  endfunction

  // excess over thr shrinks by 4, sign kept
  function automatic sample_t comp_ch(sample_t x, sample_ext_t thr);
    sample_ext_t mag;
    sample_ext_t res;
    mag = (x < 0) ? -sample_ext_t'(x) : sample_ext_t'(x);
    if (mag <= thr) return x;
    res = thr + ((mag - thr) >>> 2);
    return (x < 0) ? sample_t'(-res) : sample_t'(res);
  endfunction

  assign clip_lim = sample_ext_t'(pot_level(pot_amp_clp));
  assign comp_thr = sample_ext_t'(pot_level(pot_amp_com));
  assign clip_l   = clip_ch(in.left, clip_lim);
  assign clip_r   = clip_ch(in.right, clip_lim);

  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      c_valid   <= 1'b0;
      out.valid <= 1'b0;
    end else begin
      c_valid   <= in.valid;
      out.valid <= c_valid;
    end
  end

  // clip stage
  always_ff @(posedge tb_clk) begin
    if (clip_en) begin
      c_left  <= clip_l;
      c_right <= clip_r;
      c_sat   <= in.sat || (clip_l != in.left) || (clip_r != in.right);
    end else begin
      c_left  <= in.left;
      c_right <= in.right;
      c_sat   <= in.sat;
    end
  end

  // compress stage
  always_ff @(posedge tb_clk) begin
    out.left  <= comp_en ? comp_ch(c_left, comp_thr) : c_left;
    out.right <= comp_en ? comp_ch(c_right, comp_thr) : c_right;
    out.sat   <= c_sat;
  end

endmodule

`default_nettype wire

// ==== fader.sv ====
/*
 * fader
 * volume stage, gain glides one step per sample toward pot_vol
 */
`timescale 1ns/1ps
`default_nettype none

module fader (
  input  wire logic                 tb_clk,
  input  wire logic                 rst_n,
  input  wire logic                 fade_en,
  input  wire daf_ctrl_pkg::pot_t   pot_vol,
  sample_if.sink                    in,
  output logic                      out_valid,
  output daf_audio_pkg::stereo_t    temp_out,
  output logic                      clip_led
);
  import daf_audio_pkg::*;
  import daf_ctrl_pkg::*;

  pot_t       gain;
  logic [4:0] gain_p1;

  // x * g / 16, g in 1..16
  function automatic sample_t scale(sample_t x, logic [4:0] g);
    logic signed [21:0] prod;
    prod = x * $signed({1'b0, g});
    return sample_t'(prod >>> 4);
  endfunction

  assign gain_p1 = {1'b0, gain} + 5'd1;

  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      gain      <= '0;
      out_valid <= 1'b0;
      clip_led  <= 1'b0;
    end else begin
      out_valid <= in.valid;
      if (in.valid) begin
        clip_led <= in.sat;
        // one step toward the pot after each sample
        if (gain < pot_vol) begin
          gain <= gain + 1'b1;
        end else if (gain > pot_vol) begin
          gain <= gain - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge tb_clk) begin
    temp_out.left  <= fade_en ? scale(in.left, gain_p1) : in.left;
    temp_out.right <= fade_en ? scale(in.right, gain_p1) : in.right;
  end

endmodule

`default_nettype wire

// ==== daf.sv ====
/*
 * daf top level
 * stereo effects chain: flanger, clipper and compressor, fader
 * five cycles from in_valid to out_valid
 */
`timescale 1ns/1ps
`default_nettype none

module daf (
  input  wire logic                    tb_clk,
  input  wire logic                    rst_n,
  input  wire logic                    in_valid,
  input  wire daf_audio_pkg::stereo_t  temp_in,
  input  wire daf_ctrl_pkg::pot_t      pot_vol,
  input  wire daf_ctrl_pkg::pot_t      pot_amp_clp,
  input  wire daf_ctrl_pkg::pot_t      pot_amp_com,
  input  wire daf_ctrl_pkg::mode_t     swch_mode_en,
  input  wire logic                    mem_clr,
  output logic                         out_valid,
  output daf_audio_pkg::stereo_t       temp_out,
  output logic                         clip_led,
  output logic                         clr_busy
);

  // stage to stage links
  sample_if fl_to_dyn ();
  sample_if dyn_to_fade ();

  // 2 cycles, memory read then mix
  flanger u_flanger (
    .tb_clk    (tb_clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_smp    (temp_in),
    .flange_en (swch_mode_en.flange_en),
    .mem_clr   (mem_clr),
    .clr_busy  (clr_busy),
    .out       (fl_to_dyn.source)
  );

  // 2 cycles, clip then compress
  amp_dynamics u_amp_dynamics (
    .tb_clk      (tb_clk),
    .rst_n       (rst_n),
    .clip_en     (swch_mode_en.clip_en),
    .comp_en     (swch_mode_en.comp_en),
    .pot_amp_clp (pot_amp_clp),
    .pot_amp_com (pot_amp_com),
    .in          (fl_to_dyn.sink),
    .out         (dyn_to_fade.source)
  );

  // 1 cycle
  fader u_fader (
    .tb_clk    (tb_clk),
    .rst_n     (rst_n),
    .fade_en   (swch_mode_en.fade_en),
    .pot_vol   (pot_vol),
    .in        (dyn_to_fade.sink),
    .out_valid (out_valid),
    .temp_out  (temp_out),
    .clip_led  (clip_led)
  );

endmodule

`default_nettype wire

// ==== daf_chk.sv ====
/*
 * daf_chk
 * concurrent checks on latency, memory clear length and reset
 * state of the daf top level
 */
`timescale 1ns/1ps
`include "daf_macros.svh"
`default_nettype none

module daf_chk (
  input wire logic tb_clk,
  input wire logic rst_n,
  input wire logic in_valid,
  input wire logic clr_busy,
  input wire logic out_valid,
  input wire logic clip_led
);

  // accepted sample leaves after the fixed latency
  property p_latency;
    @(posedge tb_clk) disable iff (!rst_n)
      (in_valid && !clr_busy) |-> ##(`DAF_LATENCY) out_valid;
  endproperty
  a_latency : assert property (p_latency)
    else $error("out_valid missing after accepted input");

  // a clear ends within one pass over the memory
  property p_clr_len;
    @(posedge tb_clk) disable iff (!rst_n)
      $rose(clr_busy) |-> ##[1:`DAF_FLANGE_DEPTH + 1] !clr_busy;
  endproperty
  a_clr_len : assert property (p_clr_len)
    else $error("clr_busy held too long");

  // outputs quiet right after reset
  a_reset : assert property (@(posedge tb_clk) $rose(rst_n) |-> !out_valid && !clip_led)
    else $error("outputs active after reset");

endmodule

bind daf daf_chk u_chk (
  .tb_clk    (tb_clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .clr_busy  (clr_busy),
  .out_valid (out_valid),
  .clip_led  (clip_led)
);

`default_nettype wire

// ==== tb_daf.sv ====
/*
 * tb_daf
 * directed testbench for the daf effects chain, with a reference
 * model that predicts every output sample and its clip flag
 */
`timescale 1ns/1ps
`include "daf_macros.svh"
`default_nettype none

module tb_daf;
  import daf_audio_pkg::*;
  import daf_ctrl_pkg::*;

  logic    tb_clk;
  logic    rst_n;
  logic    in_valid;
  stereo_t temp_in;
  pot_t    pot_vol;
  pot_t    pot_amp_clp;
  pot_t    pot_amp_com;
  mode_t   swch_mode_en;
  logic    mem_clr;
  logic    out_valid;
  stereo_t temp_out;
  logic    clip_led;
  logic    clr_busy;

  // configuration as the model sees it
  mode_t   cfg_mode;
  pot_t    cfg_vol;
  pot_t    cfg_clp;
  pot_t    cfg_com;
  // reference model state
  stereo_t ref_mem [`DAF_FLANGE_DEPTH];
  int      ref_wp;
  int      ref_lfo;
  bit      ref_up;
  int      ref_gain;
  stereo_t exp_q[$];
  logic    sat_q[$];
  int      stamp_q[$];
  int      cyc;
  int      val_errs;
  int      other_errs;

  daf UUT (
    .tb_clk       (tb_clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .temp_in      (temp_in),
    .pot_vol      (pot_vol),
    .pot_amp_clp  (pot_amp_clp),
    .pot_amp_com  (pot_amp_com),
    .swch_mode_en (swch_mode_en),
    .mem_clr      (mem_clr),
    .out_valid    (out_valid),
    .temp_out     (temp_out),
    .clip_led     (clip_led),
    .clr_busy     (clr_busy)
  );

  always #20 tb_clk = ~tb_clk;

  task automatic check_stereo(string name, stereo_t exp, stereo_t act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      val_errs++;
    end
  endtask

  function automatic int level_of(pot_t p);
    return (int'(p) + 1) * 2048 - 1;
  endfunction

  function automatic int clip_ref(int x, int lim);
    if (x > lim) return lim;
    if (x < -lim) return -lim;
    return x;
  endfunction

  function automatic int comp_ref(int x, int thr);
    int mag;
    mag = (x < 0) ? -x : x;
    if (mag <= thr) return x;
    mag = thr + ((mag - thr) >>> 2);
    return (x < 0) ? -mag : mag;
  endfunction

  // one channel through clipper, compressor and fader
  function automatic int chain_ref(int x, output bit lim);
    int v;
    v = x;
    lim = 1'b0;
    if (cfg_mode.clip_en) begin
      v = clip_ref(x, level_of(cfg_clp));
      lim = (v != x);
    end
    if (cfg_mode.comp_en) v = comp_ref(v, level_of(cfg_com));
    if (cfg_mode.fade_en) v = (v * (ref_gain + 1)) >>> 4;
    return v;
  endfunction

  task automatic model_step(input stereo_t s, output stereo_t o, output logic sat);
    stereo_t tap;
    int l;
    int r;
    bit ll;
    bit lr;
    tap = ref_mem[(ref_wp + `DAF_FLANGE_DEPTH - `DAF_MIN_DELAY - ref_lfo) % `DAF_FLANGE_DEPTH];
    ref_mem[ref_wp] = s;
    ref_wp = (ref_wp + 1) % `DAF_FLANGE_DEPTH;
    if (ref_up) begin
      if (ref_lfo == `DAF_LFO_SPAN - 1) ref_up = 1'b0;
    end else if (ref_lfo == 0) begin
      ref_up = 1'b1;
    end
    ref_lfo = ref_up ? ref_lfo + 1 : ref_lfo - 1;
    l = int'(s.left);
    r = int'(s.right);
    if (cfg_mode.flange_en) begin
      l = (l + int'(tap.left)) >>> 1;
      r = (r + int'(tap.right)) >>> 1;
    end
    l = chain_ref(l, ll);
    r = chain_ref(r, lr);
    o = make_stereo(sample_t'(l), sample_t'(r));
    sat = ll || lr;
    // gain moves toward the pot after the sample
    if (ref_gain < int'(cfg_vol)) ref_gain++;
    else if (ref_gain > int'(cfg_vol)) ref_gain--;
  endtask

  // output monitor for data, flag and latency
  always @(posedge tb_clk) begin
    cyc++;
    if (in_valid && !clr_busy) stamp_q.push_back(cyc + `DAF_LATENCY);
    if (out_valid) begin
      if (exp_q.size() == 0 || stamp_q.size() == 0) begin
        $display("output sample appeared with none expected at %0t", $time);
        other_errs++;
      end else begin
        check_stereo("temp_out", exp_q.pop_front(), temp_out);
        check_bit("clip_led", sat_q.pop_front(), clip_led);
        if (stamp_q.pop_front() != cyc) begin
          $display("output sample arrived with the wrong latency at %0t", $time);
          other_errs++;
        end
      end
    end
  end

  task automatic report_timeout(string what);
    $display("timed out waiting for %s at %0t", what, $time);
    other_errs++;
  endtask

  task automatic set_cfg(mode_t m, pot_t vol, pot_t clp, pot_t com);
    cfg_mode = m;
    cfg_vol = vol;
    cfg_clp = clp;
    cfg_com = com;
    @(posedge tb_clk);
    swch_mode_en <= m;
    pot_vol <= vol;
    pot_amp_clp <= clp;
    pot_amp_com <= com;
  endtask

  task automatic send_sample(stereo_t s);
    stereo_t e;
    logic sat;
    model_step(s, e, sat);
    exp_q.push_back(e);
    sat_q.push_back(sat);
    @(posedge tb_clk);
    in_valid <= 1'b1;
    temp_in <= s;
  endtask

  task automatic wait_drained();
    int n;
    @(posedge tb_clk);
    in_valid <= 1'b0;
    n = 0;
    while (exp_q.size() != 0 || stamp_q.size() != 0) begin
      @(posedge tb_clk);
      n++;
      if (n > 50) begin
        report_timeout("pipeline to drain");
        break;
      end
    end
  endtask

  task automatic apply_reset();
    @(posedge tb_clk);
    rst_n <= 1'b0;
    repeat (4) @(posedge tb_clk);
    rst_n <= 1'b1;
    ref_wp = 0;
    ref_lfo = 0;
    ref_up = 1'b1;
    ref_gain = 0;
  endtask

  task automatic bypass_latency();
    set_cfg('0, 4'd0, 4'd0, 4'd0);
    for (int i = 0; i < 40; i++) send_sample(stereo_t'($urandom));
    wait_drained();
  endtask

  task automatic memory_clear();
    int n;
    set_cfg(4'b1000, 4'd0, 4'd0, 4'd0);
    @(posedge tb_clk);
    mem_clr <= 1'b1;
    @(posedge tb_clk);
    mem_clr <= 1'b0;
    ref_wp = 0;
    ref_lfo = 0;
    ref_up = 1'b1;
    foreach (ref_mem[i]) ref_mem[i] = '0;
    n = 0;
    while (!clr_busy) begin
      @(posedge tb_clk);
      n++;
      if (n > 4) begin
        report_timeout("clr_busy to rise");
        break;
      end
    end
    // this sample is dropped and gives no output
    in_valid <= 1'b1;
    temp_in <= make_stereo(16'sh1234, -16'sh0567);
    @(posedge tb_clk);
    in_valid <= 1'b0;
    n = 0;
    while (clr_busy) begin
      @(posedge tb_clk);
      n++;
      if (n > `DAF_FLANGE_DEPTH + 4) begin
        report_timeout("clr_busy to fall");
        break;
      end
    end
    for (int i = 0; i < `DAF_MIN_DELAY; i++) send_sample(stereo_t'($urandom));
    wait_drained();
  endtask

  task automatic flanger_sweep();
    for (int i = 0; i < 3 * `DAF_LFO_SPAN; i++) send_sample(stereo_t'($urandom));
    wait_drained();
  endtask

  task automatic clip_compress();
    sample_t vals [6] = '{16'sh7fff, -16'sh8000, 16'sh4000, -16'sh3000, 16'sh0100, 16'sh0000};
    for (int p = 0; p < 16; p += 5) begin
      for (int m = 1; m < 4; m++) begin
        set_cfg(mode_t'(m << 1), 4'd0, pot_t'(p), pot_t'(15 - p));
        foreach (vals[i]) send_sample(make_stereo(vals[i], vals[5 - i]));
        wait_drained();
      end
    end
  endtask

  task automatic fader_ramp();
    wait_drained();
    apply_reset();
    set_cfg(4'b0001, 4'd15, 4'd0, 4'd0);
    for (int i = 0; i < 20; i++) send_sample(make_stereo(16'sh7000, -16'sh5555));
    wait_drained();
    set_cfg(4'b0001, 4'd3, 4'd0, 4'd0);
    for (int i = 0; i < 20; i++) send_sample(stereo_t'($urandom));
    wait_drained();
  endtask

  initial begin
    void'($urandom(32'hd38d_b38f));
    tb_clk = 1'b0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    temp_in = '0;
    pot_vol = '0;
    pot_amp_clp = '0;
    pot_amp_com = '0;
    swch_mode_en = '0;
    mem_clr = 1'b0;
    cyc = 0;
    val_errs = 0;
    other_errs = 0;
    apply_reset();
    bypass_latency();
    memory_clear();
    flanger_sweep();
    clip_compress();
    fader_ramp();
    $display("value errors %0d, other errors %0d", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
daf_audio_pkg.sv
daf_ctrl_pkg.sv
sample_if.sv
flanger.sv
amp_dynamics.sv
fader.sv
daf.sv
daf_chk.sv
tb_daf.sv
